// ==== sim.f ====
logic/axi_mem_pkg.sv
logic/byte_mem.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/axi_mem_slave.sv
tests/tb_axi_mem_slave.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := tb_axi_mem_slave
FILELIST   := sim.f
OBJ_DIR    := obj_dir
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_axi_mem_slave.sv ====
`timescale 1ns/1ps

module tb_axi_mem_slave
  import axi_mem_pkg::*;
();

  logic clk = 1'b0;
  logic resetn;
  logic awvalid, awready, wvalid, wready, wlast, bready, bvalid;
  logic arvalid, arready, rready, rvalid, rlast;
  logic [id_w-1:0]   awid, bid, arid, rid;
  logic [addr_w-1:0] awaddr, araddr;
  logic [len_w-1:0]  awlen, arlen;
  logic [2:0]        awsize, arsize;
  logic [1:0]        awburst, arburst, bresp, rresp;
  logic [data_w-1:0] wdata, rdata;
  logic [strb_w-1:0] wstrb;

  logic [7:0]  ref_mem [mem_bytes];  // bytes as the master expects them
  string       t_name[$];
  bit          t_write[$];
  logic [31:0] t_addr[$];
  int          t_len[$];
  logic [1:0]  t_burst[$];
  logic [2:0]  t_size[$];
  logic [3:0]  t_strb[$];
  logic [1:0]  t_resp[$];
  bit          t_stall[$];            // random valid/ready gaps
  int errors = 0;
  int row_errors = 0;
  int passed = 0;
  int cycles = 0;
  int cycle_limit = 200;

  axi_mem_slave dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s expected %h actual %h", test, what, expected, actual);
      errors++;
      row_errors++;
    end
  endtask

  // byte address of a beat, counted from the start of the burst
  function automatic int beat_address(input int start, input int len,
                                      input logic [1:0] burst, input int beat);
    int block;
    int base;
    if (burst == burst_wrap) begin
      block = (len + 1) * 4;
      base  = start - (start % block);
      return base + ((start - base + 4 * beat) % block);
    end
    return (start + 4 * beat) % mem_bytes;
  endfunction

  function automatic logic [31:0] ref_word(input int a);
    return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};  // little endian lanes
  endfunction

  task automatic add_row(input string name, input bit wr, input logic [31:0] addr,
                         input int len, input logic [1:0] burst, input logic [2:0] size,
                         input logic [3:0] strb, input logic [1:0] resp, input bit stall);
    t_name.push_back(name);
    t_write.push_back(wr);
    t_addr.push_back(addr);
    t_len.push_back(len);
    t_burst.push_back(burst);
    t_size.push_back(size);
    t_strb.push_back(strb);
    t_resp.push_back(resp);
    t_stall.push_back(stall);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus masters
  //////////////////////////////////////////////////////////////////////

  task automatic write_burst(input int r);
    logic [3:0]  id_sent;
    logic [31:0] data;
    int          a;
    id_sent = 4'(r);
    awvalid <= 1'b1;
    awid    <= id_sent;
    awaddr  <= t_addr[r];
    awlen   <= 4'(t_len[r]);
    awsize  <= t_size[r];
    awburst <= t_burst[r];
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    for (int i = 0; i <= t_len[r]; i++) begin
      if (t_stall[r]) begin
        wvalid <= 1'b0;
        repeat ($urandom % 2) @(posedge clk);
      end
      data = $urandom;
      wvalid <= 1'b1;
      wdata  <= data;
      wstrb  <= t_strb[r];
      wlast  <= (i == t_len[r]);
      do @(posedge clk); while (!wready);
      if (t_resp[r] == resp_okay) begin
        a = beat_address(int'(t_addr[r]), t_len[r], t_burst[r], i);
        for (int lane = 0; lane < 4; lane++)
          if (t_strb[r][lane]) ref_mem[a + lane] = data[8*lane +: 8];
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    do @(posedge clk); while (!bvalid);
    check_value(t_name[r], "bid", 32'(id_sent), 32'(bid));
    check_value(t_name[r], "bresp", 32'(t_resp[r]), 32'(bresp));
    check_value(t_name[r], "awready", 32'(0), 32'(awready));  // busy until the response is taken
    check_value(t_name[r], "wready", 32'(0), 32'(wready));
    if (t_stall[r]) begin
      repeat (1 + $urandom % 3) begin
        @(posedge clk);  // response must wait for bready
        check_value(t_name[r], "held bvalid", 32'(1), 32'(bvalid));
        check_value(t_name[r], "held bresp", 32'(t_resp[r]), 32'(bresp));
      end
    end
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_burst(input int r);
    logic [3:0]  id_sent;
    logic [31:0] expected;
    logic [31:0] held;
    id_sent = 4'(r + 8);
    arvalid <= 1'b1;
    arid    <= id_sent;
    araddr  <= t_addr[r];
    arlen   <= 4'(t_len[r]);
    arsize  <= t_size[r];
    arburst <= t_burst[r];
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    for (int i = 0; i <= t_len[r]; i++) begin
      do @(posedge clk); while (!rvalid);
      if (t_resp[r] == resp_okay)
        expected = ref_word(beat_address(int'(t_addr[r]), t_len[r], t_burst[r], i));
      else
        expected = 32'h0;  // error bursts carry no data
      check_value(t_name[r], "rdata", expected, rdata);
      check_value(t_name[r], "rresp", 32'(t_resp[r]), 32'(rresp));
      check_value(t_name[r], "rid", 32'(id_sent), 32'(rid));
      check_value(t_name[r], "rlast", 32'(i == t_len[r]), 32'(rlast));
      check_value(t_name[r], "arready", 32'(0), 32'(arready));
      held = rdata;
      if (t_stall[r]) begin
        repeat ($urandom % 3) begin
          @(posedge clk);
          check_value(t_name[r], "held rvalid", 32'(1), 32'(rvalid));
          check_value(t_name[r], "held rdata", held, rdata);
        end
      end
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(6));
    resetn  = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = '0;
    arburst = '0;
    rready  = 1'b0;
    // name, write, addr, len, burst, size, strb, response, stall
    add_row("fill_lo",     1, 32'h00, 15, burst_incr,  size_word, 4'hf, resp_okay,   0);
    add_row("fill_hi",     1, 32'h40, 15, burst_incr,  size_word, 4'hf, resp_okay,   0);
    add_row("incr4",       1, 32'h10, 3,  burst_incr,  size_word, 4'hf, resp_okay,   0);
    add_row("wrap4_mid",   1, 32'h28, 3,  burst_wrap,  size_word, 4'hf, resp_okay,   0);
    add_row("wrap8_end",   1, 32'h7c, 7,  burst_wrap,  size_word, 4'hf, resp_okay,   0);
    add_row("strb_lo",     1, 32'h30, 3,  burst_incr,  size_word, 4'h5, resp_okay,   0);
    add_row("strb_hi",     1, 32'h34, 1,  burst_incr,  size_word, 4'h8, resp_okay,   0);
    add_row("incr_roll",   1, 32'h78, 3,  burst_incr,  size_word, 4'hf, resp_okay,   0);
    add_row("decerr",      1, 32'h80, 1,  burst_incr,  size_word, 4'hf, resp_decerr, 0);
    add_row("fixed",       1, 32'h08, 3,  burst_fixed, size_word, 4'hf, resp_slverr, 0);
    add_row("size2",       1, 32'h08, 1,  burst_incr,  3'd1,      4'hf, resp_slverr, 0);
    add_row("wrap_len6",   1, 32'h08, 5,  burst_wrap,  size_word, 4'hf, resp_slverr, 0);
    add_row("unaligned",   1, 32'h0a, 0,  burst_incr,  size_word, 4'hf, resp_slverr, 0);
    add_row("incr4_stall", 1, 32'h10, 3,  burst_incr,  size_word, 4'hf, resp_okay,   1);
    add_row("wrap_stall",  1, 32'h48, 15, burst_wrap,  size_word, 4'hf, resp_okay,   1);
    add_row("strb_stall",  1, 32'h50, 2,  burst_incr,  size_word, 4'h6, resp_okay,   1);
    add_row("read_lo",     0, 32'h00, 15, burst_incr,  size_word, 4'h0, resp_okay,   0);
    add_row("read_hi",     0, 32'h40, 15, burst_incr,  size_word, 4'h0, resp_okay,   1);
    foreach (t_name[r])
      cycle_limit += 8 * (t_len[r] + 1) + 20;
    repeat (8) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    foreach (t_name[r]) begin
      row_errors = 0;
      if (t_write[r])
        write_burst(r);
      read_burst(r);  // writes are read back over the same region
      if (row_errors == 0)
        passed++;
      $display("test %s %s", t_name[r], (row_errors == 0) ? "ok" : "failed");
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             t_name.size(), passed, t_name.size() - passed, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== logic/axi_mem_slave.sv ====
`timescale 1ns/1ps

module axi_mem_slave
  import axi_mem_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  // write address channel
  input  logic              awvalid,
  input  logic [id_w-1:0]   awid,
  input  logic [addr_w-1:0] awaddr,
  input  logic [len_w-1:0]  awlen,
  input  logic [2:0]        awsize,
  input  logic [1:0]        awburst,
  output logic              awready,
  // write data channel
  input  logic              wvalid,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  input  logic              wlast,
  output logic              wready,
  // write response channel
  input  logic              bready,
  output logic              bvalid,
  output logic [id_w-1:0]   bid,
  output logic [1:0]        bresp,
  // read address channel
  input  logic              arvalid,
  input  logic [id_w-1:0]   arid,
  input  logic [addr_w-1:0] araddr,
  input  logic [len_w-1:0]  arlen,
  input  logic [2:0]        arsize,
  input  logic [1:0]        arburst,
  output logic              arready,
  // read data channel
  input  logic              rready,
  output logic              rvalid,
  output logic [id_w-1:0]   rid,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rlast
);

  logic                  mem_we;
  logic [word_idx_w-1:0] mem_waddr;
  logic [data_w-1:0]     mem_wdata;
  logic [strb_w-1:0]     mem_wstrb;
  logic [word_idx_w-1:0] mem_raddr;
  logic [data_w-1:0]     mem_rdata;

  axi_write_engine u_write (
    .clk      (clk),       .resetn    (resetn),
    .awvalid  (awvalid),   .awid      (awid),      .awaddr   (awaddr),
    .awlen    (awlen),     .awsize    (awsize),    .awburst  (awburst),
    .awready  (awready),
    .wvalid   (wvalid),    .wdata     (wdata),     .wstrb    (wstrb),
    .wlast    (wlast),     .wready    (wready),
    .bready   (bready),    .bvalid    (bvalid),    .bid      (bid),
    .bresp    (bresp),
    .mem_we   (mem_we),    .mem_waddr (mem_waddr), .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb)
  );

  axi_read_engine u_read (
    .clk      (clk),       .resetn    (resetn),
    .arvalid  (arvalid),   .arid      (arid),      .araddr   (araddr),
    .arlen    (arlen),     .arsize    (arsize),    .arburst  (arburst),
    .arready  (arready),
    .rready   (rready),    .rvalid    (rvalid),    .rid      (rid),
    .rdata    (rdata),     .rresp     (rresp),     .rlast    (rlast),
    .mem_raddr (mem_raddr), .mem_rdata (mem_rdata)
  );

  byte_mem u_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .wstrb (mem_wstrb),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

// ==== logic/axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine
  import axi_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  resetn,
  // read address channel
  input  logic                  arvalid,
  input  logic [id_w-1:0]       arid,
  input  logic [addr_w-1:0]     araddr,
  input  logic [len_w-1:0]      arlen,
  input  logic [2:0]            arsize,
  input  logic [1:0]            arburst,
  output logic                  arready,
  // read data channel
  input  logic                  rready,
  output logic                  rvalid,
  output logic [id_w-1:0]       rid,
  output logic [data_w-1:0]     rdata,
  output logic [1:0]            rresp,
  output logic                  rlast,
  // memory read port
  output logic [word_idx_w-1:0] mem_raddr,
  input  logic [data_w-1:0]     mem_rdata
);

  enum logic {st_idle, st_data} state;

  logic [id_w-1:0]   id_q;
  logic [len_w-1:0]  len_q;
  logic [1:0]        burst_q;
  logic [addr_w-1:0] addr_q;     // address of the beat on the bus
  logic [1:0]        resp_q;
  logic [data_w-1:0] rdata_q;    // held beat data
  logic [len_w-1:0]  beat_q;     // beats already sent
  logic [1:0]        ar_resp;
  logic [addr_w-1:0] next_addr;
  logic              ar_fire;
  logic              r_fire;

  assign ar_fire   = arvalid && arready;
  assign r_fire    = rvalid && rready;
  assign ar_resp   = burst_resp(araddr, arsize, arlen, arburst);
  assign next_addr = next_beat_addr(addr_q, len_q, burst_q);

  // look up the word that will be loaded at the next transfer
  assign mem_raddr = (state == st_idle) ? araddr[word_idx_w+1:2] : next_addr[word_idx_w+1:2];

  //////////////////////////////////////////////////////////////////////
  // beat sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state  <= st_idle;
      beat_q <= '0;
    end else if (ar_fire) begin
      state  <= st_data;
      beat_q <= '0;
    end else if (r_fire) begin
      if (rlast)
        state <= st_idle;  // arready back next cycle
      beat_q <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q    <= arid;
      len_q   <= arlen;
      burst_q <= arburst;
      addr_q  <= araddr;
      resp_q  <= ar_resp;
      rdata_q <= (ar_resp == resp_okay) ? mem_rdata : '0;  // zero on error
    end else if (r_fire) begin
      addr_q  <= next_addr;
      rdata_q <= (resp_q == resp_okay) ? mem_rdata : '0;
    end
  end

  assign arready = (state == st_idle);
  assign rvalid  = (state == st_data);
  assign rlast   = rvalid && (beat_q == len_q);  // beat len+1
  assign rid     = id_q;
  assign rresp   = resp_q;
  assign rdata   = rdata_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a stalled beat must not move even if a write hits the same word
  a_r_hold: assert property (@(posedge clk) disable iff (!resetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) &&
                          $stable(rresp) && $stable(rlast))
    else $error("axi_read_engine: read beat changed while stalled");

endmodule

// ==== logic/axi_write_engine.sv ====
`timescale 1ns/1ps

module axi_write_engine
  import axi_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  resetn,
  // write address channel
  input  logic                  awvalid,
  input  logic [id_w-1:0]       awid,
  input  logic [addr_w-1:0]     awaddr,
  input  logic [len_w-1:0]      awlen,
  input  logic [2:0]            awsize,
  input  logic [1:0]            awburst,
  output logic                  awready,
  // write data channel
  input  logic                  wvalid,
  input  logic [data_w-1:0]     wdata,
  input  logic [strb_w-1:0]     wstrb,
  input  logic                  wlast,
  output logic                  wready,
  // write response channel
  input  logic                  bready,
  output logic                  bvalid,
  output logic [id_w-1:0]       bid,
  output logic [1:0]            bresp,
  // memory write port
  output logic                  mem_we,
  output logic [word_idx_w-1:0] mem_waddr,
  output logic [data_w-1:0]     mem_wdata,
  output logic [strb_w-1:0]     mem_wstrb
);

  enum logic [1:0] {st_idle, st_data, st_resp} state;

  logic [id_w-1:0]   id_q;     // echoed on bid
  logic [len_w-1:0]  len_q;    // sets the wrap block size
  logic [1:0]        burst_q;
  logic [addr_w-1:0] addr_q;   // address of the current beat
  logic [1:0]        resp_q;
  logic              aw_fire;
  logic              w_fire;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  //////////////////////////////////////////////////////////////////////
  // phase control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (aw_fire) state <= st_data;
        st_data: if (w_fire && wlast) state <= st_resp;  // wlast ends the burst
        st_resp: if (bvalid && bready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // burst context, captured once and then stepped per beat
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q    <= awid;
      len_q   <= awlen;
      burst_q <= awburst;
      addr_q  <= awaddr;
      resp_q  <= burst_resp(awaddr, awsize, awlen, awburst);
    end else if (w_fire) begin
      addr_q  <= next_beat_addr(addr_q, len_q, burst_q);
    end
  end

  assign awready = (state == st_idle);
  assign wready  = (state == st_data);
  assign bvalid  = (state == st_resp);
  assign bid     = id_q;
  assign bresp   = resp_q;

  // beats of a failed burst are taken but dropped
  assign mem_we    = w_fire && (resp_q == resp_okay);
  assign mem_waddr = addr_q[word_idx_w+1:2];  // byte address to word index
  assign mem_wdata = wdata;
  assign mem_wstrb = wstrb;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_b_hold: assert property (@(posedge clk) disable iff (!resetn)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else $error("axi_write_engine: response dropped or changed before bready");

endmodule

// ==== logic/byte_mem.sv ====
`timescale 1ns/1ps

module byte_mem
  import axi_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  we,
  input  logic [word_idx_w-1:0] waddr,
  input  logic [data_w-1:0]     wdata,
  input  logic [strb_w-1:0]     wstrb,
  input  logic [word_idx_w-1:0] raddr,
  output logic [data_w-1:0]     rdata
);

  logic [data_w-1:0] mem [mem_words];  // word storage, lanes written separately

  always_ff @(posedge clk) begin
    if (we) begin
      for (int lane = 0; lane < strb_w; lane++) begin
        if (wstrb[lane])
          mem[waddr][8*lane +: 8] <= wdata[8*lane +: 8];  // enabled lane only
      end
    end
  end

  // a same-cycle write is seen one cycle later, so the old word comes out
  assign rdata = mem[raddr];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the write engine resets asynchronously, so we is defined at every edge
  a_we_known: assert property (@(posedge clk) !$isunknown(we))
    else $error("byte_mem: write enable is unknown");

endmodule

// ==== logic/axi_mem_pkg.sv ====
package axi_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus and storage geometry
  //////////////////////////////////////////////////////////////////////

  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int strb_w     = data_w / 8;  // one strobe per byte lane
  localparam int id_w       = 4;
  localparam int len_w      = 4;           // 1 to 16 beats
  localparam int mem_bytes  = 128;
  localparam int mem_words  = mem_bytes / strb_w;
  localparam int word_idx_w = $clog2(mem_words);

  //////////////////////////////////////////////////////////////////////
  // AXI encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] size_word   = 3'd2;  // 4 bytes per beat
  localparam logic [1:0] burst_fixed = 2'd0;
  localparam logic [1:0] burst_incr  = 2'd1;
  localparam logic [1:0] burst_wrap  = 2'd2;
  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;
  localparam logic [1:0] resp_decerr = 2'd3;

  // address of the beat that follows addr within the burst
  function automatic logic [addr_w-1:0] next_beat_addr(input logic [addr_w-1:0] addr,
                                                       input logic [len_w-1:0]  len,
                                                       input logic [1:0]        burst);
    logic [addr_w-1:0] step;
    logic [addr_w-1:0] wrap_mask;
    step      = addr + addr_w'(strb_w);
    wrap_mask = ((addr_w'(len) + addr_w'(1)) << 2) - addr_w'(1);  // block is (len+1)*4 bytes
    case (burst)
      burst_incr: return step & addr_w'(mem_bytes - 1);  // rolls over at end of storage
      burst_wrap: return (addr & ~wrap_mask) | (step & wrap_mask);
      default:    return addr;
    endcase
  endfunction

  // response for a whole burst, decided from the address phase alone
  function automatic logic [1:0] burst_resp(input logic [addr_w-1:0] addr,
                                            input logic [2:0]        size,
                                            input logic [len_w-1:0]  len,
                                            input logic [1:0]        burst);
    logic wrap_len_ok;
    logic bad_burst;
    wrap_len_ok = len inside {4'd1, 4'd3, 4'd7, 4'd15};
    bad_burst   = !(burst inside {burst_incr, burst_wrap});  // fixed or reserved
    if (addr >= addr_w'(mem_bytes))
      return resp_decerr;
    if (size != size_word || addr[1:0] != 2'b00 || bad_burst ||
        (burst == burst_wrap && !wrap_len_ok))
      return resp_slverr;
    return resp_okay;
  endfunction

endpackage
